// File: verilog/core_pkg.sv
// Shared types and encodings for the four-stage RV32I core.
// Compile this package before any RTL or testbench file.
`default_nettype none

package core_pkg;

    // Basic data types of the RV32 datapath
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } rv_opcode_e;

    // ALU functions, PASS_B forwards the U immediate for LUI
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
    } alu_op_e;

    // What an instruction does after decode
    typedef enum logic [1:0] {
        CLS_NOP, CLS_ALU, CLS_LOAD, CLS_STORE
    } op_class_e;

    // funct3 values
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ADDI x0,x0,0
    localparam word_t    NOP_INSTR    = 32'h0000_0013;
    localparam byte_en_t FULL_WORD_EN = 4'b1111;

endpackage

`default_nettype wire

// File: verilog/fetch_stage.sv
// Fetch stage: program counter, instruction memory request and the
// valid/ready link towards decode. A word that decode cannot take is
// parked in a one-entry skid register, and no request goes out meanwhile.
`default_nettype none

module fetch_stage #(
    parameter core_pkg::word_t START_ADDR = 32'h0
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            stall_i,
    input  logic            ready_i,
    input  core_pkg::word_t instruction_i,
    output logic            imem_operation_enable_o,
    output core_pkg::word_t instruction_address_o,
    output logic            valid_o,
    output core_pkg::word_t instr_o,
    output core_pkg::word_t pc_o
);
    import core_pkg::*;

    logic  started_q;
    word_t pc_q;
    // Word on instruction_i not yet consumed
    logic  pend_q;
    word_t pend_pc_q;
    logic  skid_q;
    word_t skid_instr_q;
    word_t skid_pc_q;

    assign imem_operation_enable_o = started_q && !skid_q;
    assign instruction_address_o   = pc_q;

    // Skid word is older, so it goes first
    assign valid_o = skid_q || pend_q;
    assign instr_o = skid_q ? skid_instr_q : instruction_i;
    assign pc_o    = skid_q ? skid_pc_q : pend_pc_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            started_q <= 1'b0;
            pc_q      <= START_ADDR;
            pend_q    <= 1'b0;
            skid_q    <= 1'b0;
        end else if (!stall_i) begin
            started_q <= 1'b1;
            if (imem_operation_enable_o) begin
                pc_q <= pc_q + 32'd4;
            end
            // Memory keeps its word while no new request is issued
            pend_q <= imem_operation_enable_o || (pend_q && skid_q);
            if (skid_q) begin
                if (ready_i) begin
                    skid_q <= 1'b0;
                end
            end else if (pend_q && !ready_i) begin
                skid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            if (imem_operation_enable_o) begin
                pend_pc_q <= pc_q;
            end
            if (!skid_q && pend_q && !ready_i) begin
                skid_instr_q <= instruction_i;
                skid_pc_q    <= pend_pc_q;
            end
        end
    end

    a_addr_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        imem_operation_enable_o |-> instruction_address_o[1:0] == 2'b00);

    // Held word must not change under back-pressure
    a_instr_held: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o && !ready_i |=> $stable(instr_o) && valid_o);

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
// Decode stage: decodes the word offered by fetch, picks operands from the
// register bank or the forwarding paths, and loads the execute register.
// A source that needs the load now in execute holds the word one cycle
// and sends a bubble instead.
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                stall_i,
    input  logic                valid_i,
    input  core_pkg::word_t     instr_i,
    input  core_pkg::word_t     pc_i,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    input  logic                fwd_x_we_i,
    input  core_pkg::reg_idx_t  fwd_x_rd_i,
    input  core_pkg::word_t     fwd_x_data_i,
    input  core_pkg::reg_idx_t  x_load_rd_i,
    input  logic                wb_we_i,
    input  core_pkg::reg_idx_t  wb_rd_i,
    input  core_pkg::word_t     wb_data_i,
    output logic                ready_o,
    output core_pkg::reg_idx_t  rs1_idx_o,
    output core_pkg::reg_idx_t  rs2_idx_o,
    output logic                x_valid_o,
    output core_pkg::op_class_e x_class_o,
    output core_pkg::alu_op_e   x_alu_op_o,
    output core_pkg::reg_idx_t  x_rd_o,
    output core_pkg::word_t     x_operand_a_o,
    output core_pkg::word_t     x_operand_b_o,
    output core_pkg::word_t     x_store_data_o
);
    import core_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    op_class_e  cls;
    alu_op_e    alu_op;
    word_t      operand_b;
    logic       use_rs1;
    logic       use_rs2;
    logic       use_imm;
    logic       hazard;
    word_t      rs1_val;
    word_t      rs2_val;

    // Execute result wins over write-back, x0 never forwarded
    function automatic word_t fwd_operand(reg_idx_t idx, word_t bank_data);
        word_t v;
        v = bank_data;
        if (wb_we_i && wb_rd_i == idx && idx != '0) begin
            v = wb_data_i;
        end
        if (fwd_x_we_i && fwd_x_rd_i == idx && idx != '0) begin
            v = fwd_x_data_i;
        end
        return v;
    endfunction

    ////////////////////
    // Field decode
    ////////////////////

    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];
    assign rd        = instr_i[11:7];
    assign funct3    = instr_i[14:12];
    assign funct7    = instr_i[31:25];
    assign imm_i     = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u     = {instr_i[31:12], 12'b0};

    always_comb begin
        cls     = CLS_NOP;
        alu_op  = ALU_ADD;
        use_rs2 = 1'b0;
        use_imm = 1'b1;
        case (rv_opcode_e'(instr_i[6:0]))
            OPC_OP_IMM: begin
                cls = CLS_ALU;
                case (funct3)
                    F3_ADD: alu_op = ALU_ADD;
                    F3_AND: alu_op = ALU_AND;
                    F3_OR:  alu_op = ALU_OR;
                    F3_XOR: alu_op = ALU_XOR;
                    F3_SLT: alu_op = ALU_SLT;
                    F3_SLL: alu_op = ALU_SLL;
                    F3_SRL: alu_op = ALU_SRL;
                    default: cls = CLS_NOP;
                endcase
                // Shifts by immediate need a zero funct7, SRAI is not supported
                if ((funct3 == F3_SLL || funct3 == F3_SRL) && funct7 != F7_BASE) begin
                    cls = CLS_NOP;
                end
            end
            OPC_OP: begin
                cls     = CLS_ALU;
                use_rs2 = 1'b1;
                use_imm = 1'b0;
                case (funct3)
                    F3_ADD: alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_AND: alu_op = ALU_AND;
                    F3_OR:  alu_op = ALU_OR;
                    F3_XOR: alu_op = ALU_XOR;
                    F3_SLT: alu_op = ALU_SLT;
                    F3_SLL: alu_op = ALU_SLL;
                    default: alu_op = ALU_SRL;
                endcase
                if (funct7 != F7_BASE && !(funct7 == F7_SUB && funct3 == F3_ADD)) begin
                    cls = CLS_NOP;
                end
            end
            OPC_LUI: begin
                cls    = CLS_ALU;
                alu_op = ALU_PASS_B;
            end
            OPC_LOAD: begin
                cls = (funct3 == F3_WORD) ? CLS_LOAD : CLS_NOP;
            end
            OPC_STORE: begin
                cls     = (funct3 == F3_WORD) ? CLS_STORE : CLS_NOP;
                use_rs2 = 1'b1;
            end
            default: cls = CLS_NOP;
        endcase
    end

    assign use_rs1 = cls != CLS_NOP && alu_op != ALU_PASS_B;

    // Immediate by format
    always_comb begin
        if (!use_imm) begin
            operand_b = rs2_val;
        end else if (cls == CLS_STORE) begin
            operand_b = imm_s;
        end else if (alu_op == ALU_PASS_B) begin
            operand_b = imm_u;
        end else begin
            operand_b = imm_i;
        end
    end

    ////////////////////
    // Operands, hazard
    ////////////////////

    always_comb begin
        rs1_val = fwd_operand(rs1_idx_o, rs1_data_i);
        rs2_val = fwd_operand(rs2_idx_o, rs2_data_i);
    end

    // Load data only exists once the load reaches retire
    assign hazard = valid_i && x_load_rd_i != '0 &&
                    ((use_rs1 && rs1_idx_o == x_load_rd_i) ||
                     (use_rs2 && rs2_idx_o == x_load_rd_i));
    assign ready_o = !hazard;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            x_valid_o <= 1'b0;
            x_class_o <= CLS_NOP;
            x_rd_o    <= '0;
        end else if (!stall_i) begin
            x_valid_o <= valid_i && !hazard;
            x_class_o <= cls;
            x_rd_o    <= (cls == CLS_ALU || cls == CLS_LOAD) ? rd : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            x_alu_op_o     <= alu_op;
            x_operand_a_o  <= rs1_val;
            x_operand_b_o  <= operand_b;
            x_store_data_o <= rs2_val;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        valid_i |-> pc_i[1:0] == 2'b00);

    // Load-use hold never lasts past one cycle
    a_hold_once: assert property (@(posedge clk) disable iff (!reset_n)
        !ready_o && !stall_i |=> ready_o);

endmodule

`default_nettype wire

// File: verilog/register_bank.sv
// Integer register bank: 31 writable registers, x0 reads as zero.
// Two asynchronous read ports for decode, one write port from retire.
`default_nettype none

module register_bank (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               we_i,
    input  core_pkg::reg_idx_t rd_i,
    input  core_pkg::word_t    wdata_i,
    input  core_pkg::reg_idx_t rs1_idx_i,
    input  core_pkg::reg_idx_t rs2_idx_i,
    output core_pkg::word_t    rs1_data_o,
    output core_pkg::word_t    rs2_data_o
);
    import core_pkg::*;

    word_t regs [1:31];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // x0 has no storage
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

    a_rd_known: assert property (@(posedge clk) disable iff (!reset_n)
        we_i |-> !$isunknown(rd_i));

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
// Execute stage: ALU over the execute register, data memory request
// for LW/SW, and the register towards retire. Also returns the ALU
// result and the destination of a pending load to decode.
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                stall_i,
    input  logic                x_valid_i,
    input  core_pkg::op_class_e x_class_i,
    input  core_pkg::alu_op_e   x_alu_op_i,
    input  core_pkg::reg_idx_t  x_rd_i,
    input  core_pkg::word_t     x_operand_a_i,
    input  core_pkg::word_t     x_operand_b_i,
    input  core_pkg::word_t     x_store_data_i,
    output logic                fwd_x_we_o,
    output core_pkg::reg_idx_t  fwd_x_rd_o,
    output core_pkg::word_t     fwd_x_data_o,
    output core_pkg::reg_idx_t  x_load_rd_o,
    output logic                dmem_operation_enable_o,
    output core_pkg::byte_en_t  mem_write_enable_o,
    output core_pkg::word_t     mem_address_o,
    output core_pkg::word_t     mem_data_o,
    output logic                r_we_o,
    output core_pkg::reg_idx_t  r_rd_o,
    output logic                r_is_load_o,
    output core_pkg::word_t     r_result_o
);
    import core_pkg::*;

    word_t alu_result;
    logic  is_alu;
    logic  is_load;
    logic  is_store;

    assign is_alu   = x_valid_i && x_class_i == CLS_ALU;
    assign is_load  = x_valid_i && x_class_i == CLS_LOAD;
    assign is_store = x_valid_i && x_class_i == CLS_STORE;

    always_comb begin
        case (x_alu_op_i)
            ALU_SUB: alu_result = x_operand_a_i - x_operand_b_i;
            ALU_AND: alu_result = x_operand_a_i & x_operand_b_i;
            ALU_OR:  alu_result = x_operand_a_i | x_operand_b_i;
            ALU_XOR: alu_result = x_operand_a_i ^ x_operand_b_i;
            ALU_SLT: alu_result = {31'b0, $signed(x_operand_a_i) < $signed(x_operand_b_i)};
            ALU_SLL: alu_result = x_operand_a_i << x_operand_b_i[4:0];
            ALU_SRL: alu_result = x_operand_a_i >> x_operand_b_i[4:0];
            ALU_PASS_B: alu_result = x_operand_b_i;
            default: alu_result = x_operand_a_i + x_operand_b_i;
        endcase
    end

    ////////////////////
    // Forwarding
    ////////////////////

    // Load results are not ready here, decode stalls on them instead
    assign fwd_x_we_o   = is_alu && x_rd_i != '0;
    assign fwd_x_rd_o   = x_rd_i;
    assign fwd_x_data_o = alu_result;
    assign x_load_rd_o  = is_load ? x_rd_i : '0;

    ////////////////////
    // Data memory
    ////////////////////

    assign dmem_operation_enable_o = is_load || is_store;
    assign mem_write_enable_o      = is_store ? FULL_WORD_EN : '0;
    // Word access only
    assign mem_address_o           = {alu_result[31:2], 2'b00};
    assign mem_data_o              = x_store_data_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_we_o      <= 1'b0;
            r_rd_o      <= '0;
            r_is_load_o <= 1'b0;
        end else if (!stall_i) begin
            r_we_o      <= (is_alu || is_load) && x_rd_i != '0;
            r_rd_o      <= x_rd_i;
            r_is_load_o <= is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            r_result_o <= alu_result;
        end
    end

    a_we_has_enable: assert property (@(posedge clk) disable iff (!reset_n)
        |mem_write_enable_o |-> dmem_operation_enable_o);

    // Request is frozen across a memory stall
    a_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> $stable({dmem_operation_enable_o, mem_write_enable_o,
                             mem_address_o, mem_data_o}));

endmodule

`default_nettype wire

// File: verilog/retire_stage.sv
// Retire stage: chooses load data or the ALU result and drives the
// register bank write port and decode's write-back forwarding path.
`default_nettype none

module retire_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               stall_i,
    input  logic               r_we_i,
    input  core_pkg::reg_idx_t r_rd_i,
    input  logic               r_is_load_i,
    input  core_pkg::word_t    r_result_i,
    input  core_pkg::word_t    mem_data_i,
    output logic               wb_we_o,
    output core_pkg::reg_idx_t wb_rd_o,
    output core_pkg::word_t    wb_data_o
);

    // No write while stalled, x0 never written
    assign wb_we_o   = r_we_i && !stall_i && r_rd_i != '0;
    assign wb_rd_o   = r_rd_i;
    // Read data arrives one cycle after the request in execute
    assign wb_data_o = r_is_load_i ? mem_data_i : r_result_i;

    a_load_data_known: assert property (@(posedge clk) disable iff (!reset_n)
        wb_we_o && r_is_load_i |-> !$isunknown(mem_data_i));

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
// Top level of the four-stage RV32I core: fetch, decode, execute and
// retire around one register bank. stall_i freezes the whole pipeline
// while a memory is busy. Set START_ADDR to the first fetch address.
`default_nettype none

module rv_core #(
    parameter core_pkg::word_t START_ADDR = 32'h0
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               stall_i,
    output logic               imem_operation_enable_o,
    output core_pkg::word_t    instruction_address_o,
    input  core_pkg::word_t    instruction_i,
    output logic               dmem_operation_enable_o,
    output core_pkg::byte_en_t mem_write_enable_o,
    output core_pkg::word_t    mem_address_o,
    output core_pkg::word_t    mem_data_o,
    input  core_pkg::word_t    mem_data_i
);
    import core_pkg::*;

    ////////////////////
    // Stage links
    ////////////////////

    // Fetch to decode
    logic      f_valid;
    logic      d_ready;
    word_t     f_instr;
    word_t     f_pc;
    // Register bank reads
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    word_t     rs1_data;
    word_t     rs2_data;
    // Execute register
    logic      x_valid;
    op_class_e x_class;
    alu_op_e   x_alu_op;
    reg_idx_t  x_rd;
    word_t     x_operand_a;
    word_t     x_operand_b;
    word_t     x_store_data;
    // Execute forwarding
    logic      fwd_x_we;
    reg_idx_t  fwd_x_rd;
    word_t     fwd_x_data;
    reg_idx_t  x_load_rd;
    // Retire register and write-back
    logic      r_we;
    reg_idx_t  r_rd;
    logic      r_is_load;
    word_t     r_result;
    logic      wb_we;
    reg_idx_t  wb_rd;
    word_t     wb_data;

    fetch_stage #(
        .START_ADDR (START_ADDR)
    ) i_fetch (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .stall_i                 (stall_i),
        .ready_i                 (d_ready),
        .instruction_i           (instruction_i),
        .imem_operation_enable_o (imem_operation_enable_o),
        .instruction_address_o   (instruction_address_o),
        .valid_o                 (f_valid),
        .instr_o                 (f_instr),
        .pc_o                    (f_pc)
    );

    decode_stage i_decode (
        .clk            (clk),
        .reset_n        (reset_n),
        .stall_i        (stall_i),
        .valid_i        (f_valid),
        .instr_i        (f_instr),
        .pc_i           (f_pc),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .fwd_x_we_i     (fwd_x_we),
        .fwd_x_rd_i     (fwd_x_rd),
        .fwd_x_data_i   (fwd_x_data),
        .x_load_rd_i    (x_load_rd),
        .wb_we_i        (wb_we),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .ready_o        (d_ready),
        .rs1_idx_o      (rs1_idx),
        .rs2_idx_o      (rs2_idx),
        .x_valid_o      (x_valid),
        .x_class_o      (x_class),
        .x_alu_op_o     (x_alu_op),
        .x_rd_o         (x_rd),
        .x_operand_a_o  (x_operand_a),
        .x_operand_b_o  (x_operand_b),
        .x_store_data_o (x_store_data)
    );

    register_bank i_regbank (
        .clk        (clk),
        .reset_n    (reset_n),
        .we_i       (wb_we),
        .rd_i       (wb_rd),
        .wdata_i    (wb_data),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute_stage i_execute (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .stall_i                 (stall_i),
        .x_valid_i               (x_valid),
        .x_class_i               (x_class),
        .x_alu_op_i              (x_alu_op),
        .x_rd_i                  (x_rd),
        .x_operand_a_i           (x_operand_a),
        .x_operand_b_i           (x_operand_b),
        .x_store_data_i          (x_store_data),
        .fwd_x_we_o              (fwd_x_we),
        .fwd_x_rd_o              (fwd_x_rd),
        .fwd_x_data_o            (fwd_x_data),
        .x_load_rd_o             (x_load_rd),
        .dmem_operation_enable_o (dmem_operation_enable_o),
        .mem_write_enable_o      (mem_write_enable_o),
        .mem_address_o           (mem_address_o),
        .mem_data_o              (mem_data_o),
        .r_we_o                  (r_we),
        .r_rd_o                  (r_rd),
        .r_is_load_o             (r_is_load),
        .r_result_o              (r_result)
    );

    retire_stage i_retire (
        .clk         (clk),
        .reset_n     (reset_n),
        .stall_i     (stall_i),
        .r_we_i      (r_we),
        .r_rd_i      (r_rd),
        .r_is_load_i (r_is_load),
        .r_result_i  (r_result),
        .mem_data_i  (mem_data_i),
        .wb_we_o     (wb_we),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

endmodule

`default_nettype wire

// File: bench/tb_program.svh
// Test program for the RV32I core testbench, included inside the bench module.
// Holds the instruction words fetched from START_ADDR upwards, the stores the
// program must produce in order, and the data words preset before each pass.
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN    = 48;
localparam int STORE_COUNT = 22;
localparam int PRESET_LEN  = 2;

// One instruction word per entry, fetched in order
word_t prog_words [PROG_LEN] = '{
    32'h0050_0093,  // addi x1, x0, 5
    32'hFFD0_0113,  // addi x2, x0, -3
    32'h0410_2023,  // sw   x1, 64(x0)   first data access
    32'h0F01_7193,  // andi x3, x2, 0x0f0
    32'h0430_2223,  // sw   x3, 68(x0)   result of previous instr
    32'h7000_E213,  // ori  x4, x1, 0x700
    32'hFFF1_4293,  // xori x5, x2, -1
    32'hFFE1_2313,  // slti x6, x2, -2
    32'h0040_9393,  // slli x7, x1, 4
    32'h01C1_5413,  // srli x8, x2, 28
    32'hABCD_E4B7,  // lui  x9, 0xabcde
    32'h0440_2423,  // sw   x4, 72(x0)
    32'h0450_2623,  // sw   x5, 76(x0)
    32'h0460_2823,  // sw   x6, 80(x0)
    32'h0470_2A23,  // sw   x7, 84(x0)
    32'h0480_2C23,  // sw   x8, 88(x0)
    32'h0490_2E23,  // sw   x9, 92(x0)
    32'h4020_8533,  // sub  x10, x1, x2
    32'h0024_F5B3,  // and  x11, x9, x2
    32'h0070_E633,  // or   x12, x1, x7
    32'h0044_C6B3,  // xor  x13, x9, x4
    32'h0011_2733,  // slt  x14, x2, x1
    32'h0020_A7B3,  // slt  x15, x1, x2
    32'h0080_9833,  // sll  x16, x1, x8
    32'h0014_D8B3,  // srl  x17, x9, x1
    32'h0020_8933,  // add  x18, x1, x2
    32'h0010_8033,  // add  x0, x1, x1   dropped write
    32'h0720_2023,  // sw   x18, 96(x0)  two instrs after producer
    32'h06A0_2223,  // sw   x10, 100(x0)
    32'h06B0_2423,  // sw   x11, 104(x0)
    32'h06C0_2623,  // sw   x12, 108(x0)
    32'h06D0_2823,  // sw   x13, 112(x0)
    32'h06E0_2A23,  // sw   x14, 116(x0)
    32'h06F0_2C23,  // sw   x15, 120(x0)
    32'h0700_2E23,  // sw   x16, 124(x0)
    32'h0910_2023,  // sw   x17, 128(x0)
    32'h0800_2223,  // sw   x0, 132(x0)
    32'h0640_8993,  // addi x19, x1, 100
    32'h0139_8A33,  // add  x20, x19, x19
    32'h0940_2423,  // sw   x20, 136(x0)
    32'h0200_2A83,  // lw   x21, 32(x0)
    32'h001A_8B13,  // addi x22, x21, 1  load-use
    32'h0960_2623,  // sw   x22, 140(x0)
    32'h0240_2B83,  // lw   x23, 36(x0)
    32'h0970_2823,  // sw   x23, 144(x0) load-use on store data
    32'h0400_2C03,  // lw   x24, 64(x0)  reads back first store
    32'h402C_0CB3,  // sub  x25, x24, x2
    32'h0990_2A23   // sw   x25, 148(x0)
};

// Expected stores in program order, {address, data}
logic [63:0] store_table [STORE_COUNT] = '{
    {32'h0000_0040, 32'h0000_0005},
    {32'h0000_0044, 32'h0000_00F0},
    {32'h0000_0048, 32'h0000_0705},
    {32'h0000_004C, 32'h0000_0002},
    {32'h0000_0050, 32'h0000_0001},
    {32'h0000_0054, 32'h0000_0050},
    {32'h0000_0058, 32'h0000_000F},
    {32'h0000_005C, 32'hABCD_E000},
    {32'h0000_0060, 32'h0000_0002},
    {32'h0000_0064, 32'h0000_0008},
    {32'h0000_0068, 32'hABCD_E000},
    {32'h0000_006C, 32'h0000_0055},
    {32'h0000_0070, 32'hABCD_E705},
    {32'h0000_0074, 32'h0000_0001},
    {32'h0000_0078, 32'h0000_0000},
    {32'h0000_007C, 32'h0002_8000},
    {32'h0000_0080, 32'h055E_6F00},
    {32'h0000_0084, 32'h0000_0000},
    {32'h0000_0088, 32'h0000_00D2},
    {32'h0000_008C, 32'h1234_5679},
    {32'h0000_0090, 32'h8000_0001},
    {32'h0000_0094, 32'h0000_0008}
};

// Data words read by the loads, {address, data}
logic [63:0] dmem_preset [PRESET_LEN] = '{
    {32'h0000_0020, 32'h1234_5678},
    {32'h0000_0024, 32'h8000_0001}
};

`endif

// File: bench/rv_core_tb.sv
// Testbench for the four-stage RV32I core.
// Runs the program table twice, first without and then with random memory
// stalls, and checks every data memory write against the expected stores.
// Both memories are modelled here with one-cycle reads.
`default_nettype none

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    `include "tb_program.svh"

    localparam word_t START_ADDR     = 32'h100;
    localparam int    RESET_CYCLES   = 16;
    localparam int    TIMEOUT_CYCLES = 4 * (PROG_LEN + RESET_CYCLES) + 50;
    localparam int    DRAIN_CYCLES   = 10;
    localparam int    DMEM_WORDS     = 64;

    logic     clk;
    logic     reset_n;
    logic     stall_i;
    logic     imem_operation_enable_o;
    word_t    instruction_address_o;
    word_t    instruction_i;
    logic     dmem_operation_enable_o;
    byte_en_t mem_write_enable_o;
    word_t    mem_address_o;
    word_t    mem_data_o;
    word_t    mem_data_i;

    // Memory model state
    word_t  dmem [DMEM_WORDS];
    word_t  imem_word_q;
    word_t  dmem_word_q;
    // Run control
    integer seed;
    logic   random_stall;
    int     pass_no;
    int     cycles;
    int     store_idx;
    logic   first_fetch_seen;

    rv_core #(
        .START_ADDR (START_ADDR)
    ) i_rv_core (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .stall_i                 (stall_i),
        .imem_operation_enable_o (imem_operation_enable_o),
        .instruction_address_o   (instruction_address_o),
        .instruction_i           (instruction_i),
        .dmem_operation_enable_o (dmem_operation_enable_o),
        .mem_write_enable_o      (mem_write_enable_o),
        .mem_address_o           (mem_address_o),
        .mem_data_o              (mem_data_o),
        .mem_data_i              (mem_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_strobe(input string name, input byte_en_t expected,
                                input byte_en_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    ////////////////////
    // Memory models
    ////////////////////

    // NOP outside the program
    function automatic word_t fetch_word(input word_t addr);
        word_t       offset;
        int unsigned idx;
        offset = addr - START_ADDR;
        idx    = offset >> 2;
        if (addr < START_ADDR || idx >= PROG_LEN) begin
            return NOP_INSTR;
        end
        return prog_words[idx];
    endfunction

    // Background pattern from the byte address, then the preset words
    task automatic load_data_memory();
        word_t addr;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hD5A0_0000 | (i << 2);
        end
        for (int k = 0; k < PRESET_LEN; k++) begin
            addr            = dmem_preset[k][63:32];
            dmem[addr[7:2]] = dmem_preset[k][31:0];
        end
    endtask

    // Accesses count only on edges without stall
    always @(posedge clk) begin
        if (reset_n && !stall_i) begin
            if (imem_operation_enable_o) begin
                imem_word_q <= fetch_word(instruction_address_o);
            end
            if (dmem_operation_enable_o) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_write_enable_o[b]) begin
                        dmem[mem_address_o[7:2]][8*b +: 8] <= mem_data_o[8*b +: 8];
                    end
                end
                if (mem_write_enable_o == '0) begin
                    dmem_word_q <= dmem[mem_address_o[7:2]];
                end
            end
        end
    end

    // Read data and stall change on the falling edge
    always @(negedge clk) begin
        instruction_i <= imem_word_q;
        mem_data_i    <= dmem_word_q;
        if (random_stall) begin
            stall_i <= ($random(seed) & 3) == 0;
        end else begin
            stall_i <= 1'b0;
        end
    end

    ////////////////////
    // Store monitor
    ////////////////////

    always @(posedge clk) begin
        if (!reset_n) begin
            store_idx        <= 0;
            first_fetch_seen <= 1'b0;
        end else if (!stall_i) begin
            if (imem_operation_enable_o && !first_fetch_seen) begin
                check_word("first fetch address", START_ADDR, instruction_address_o);
                first_fetch_seen <= 1'b1;
            end
            // Program does no load before its first store
            if (dmem_operation_enable_o && store_idx == 0) begin
                check_strobe("access before first store", 4'b1111, mem_write_enable_o);
            end
            if (dmem_operation_enable_o && mem_write_enable_o != '0) begin
                if (store_idx >= STORE_COUNT) begin
                    $display("Unexpected store to %h after the last expected store in pass %0d",
                             mem_address_o, pass_no);
                    $display("Simulation failed");
                    $fatal(1);
                end
                check_word($sformatf("pass %0d store %0d address", pass_no, store_idx),
                           store_table[store_idx][63:32], mem_address_o);
                check_word($sformatf("pass %0d store %0d data", pass_no, store_idx),
                           store_table[store_idx][31:0], mem_data_o);
                check_strobe($sformatf("pass %0d store %0d byte enables", pass_no, store_idx),
                             4'b1111, mem_write_enable_o);
                store_idx <= store_idx + 1;
            end
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed          = 32'hf6cf3d2c;
        reset_n       = 1'b0;
        stall_i       = 1'b0;
        instruction_i = NOP_INSTR;
        mem_data_i    = '0;
        imem_word_q   = NOP_INSTR;
        dmem_word_q   = '0;
        random_stall  = 1'b0;
        pass_no       = 0;

        // Pass 0 without stall, pass 1 with random stall
        for (int p = 0; p < 2; p++) begin
            @(negedge clk);
            pass_no      = p;
            reset_n      = 1'b0;
            random_stall = 1'b0;
            load_data_memory();
            repeat (RESET_CYCLES) @(negedge clk);
            cycles       = RESET_CYCLES;
            reset_n      = 1'b1;
            random_stall = (p == 1);

            while (store_idx < STORE_COUNT && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                cycles++;
            end
            if (store_idx < STORE_COUNT) begin
                $display("Timeout in pass %0d after %0d cycles, %0d of %0d stores seen",
                         p, cycles, store_idx, STORE_COUNT);
                $display("Simulation failed");
                $fatal(1);
            end
            // Trailing NOPs must not produce stores
            repeat (DRAIN_CYCLES) @(negedge clk);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_bank.sv
verilog/execute_stage.sv
verilog/retire_stage.sv
verilog/rv_core.sv
+incdir+bench
bench/rv_core_tb.sv
